// File: compile.f
rtl/setup_pkg.sv
rtl/setup_fifo.sv
rtl/serial_read_engine.sv
rtl/setup_response_collector.sv
rtl/kernel_setup.sv
tb/tb_memory_model.sv
tb/tb_kernel_setup.sv

// File: tb/tb_kernel_setup.sv
`timescale 1ns/10ps
`default_nettype none

module tb_kernel_setup;

    import setup_pkg::*;

    localparam int NUM_ROWS       = 6;
    localparam int TIMEOUT_CYCLES = NUM_ROWS * 200;
    localparam int QUIET_CYCLES   = 20;

    typedef struct packed {
        logic [ADDR_W-1:0] pointer;
        logic              backpressure;
        logic              reverse_order;
    } scenario_t;

    logic                ap_clk;
    logic                setup_areset;
    descriptor_t         descriptor_in;
    memory_response_t    resp_in;
    logic                req_rd_en;
    memory_request_t     req_out;
    logic                setup_done;
    graph_csr_config_t   setup_config;
    logic                backpressure;
    logic                reverse_order;

    scenario_t           scenarios [NUM_ROWS];
    graph_csr_config_t   expected_cfg;
    logic [ADDR_W-1:0]   seen_addr [$];
    logic [REQ_ID_W-1:0] seen_id [$];
    int                  error_count;
    int                  cycle_count;

    kernel_setup #(
        .FIFO_DEPTH (16)
    ) kernel_setup_inst (
        .ap_clk        (ap_clk),
        .setup_areset  (setup_areset),
        .descriptor_in (descriptor_in),
        .resp_in       (resp_in),
        .req_rd_en     (req_rd_en),
        .req_out       (req_out),
        .setup_done    (setup_done),
        .setup_config  (setup_config)
    );

    tb_memory_model memory_model_inst (
        .ap_clk        (ap_clk),
        .areset        (setup_areset),
        .backpressure  (backpressure),
        .reverse_order (reverse_order),
        .req_out       (req_out),
        .req_rd_en     (req_rd_en),
        .resp_in       (resp_in)
    );

    initial ap_clk = 1'b0;
    always #5 ap_clk = ~ap_clk;

    // Log every request the memory takes
    always @(negedge ap_clk) begin
        if (req_out.valid && req_rd_en) begin
            seen_addr.push_back(req_out.payload.address);
            seen_id.push_back(req_out.payload.id);
        end
    end

    always @(posedge ap_clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, setup never finished", cycle_count);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    task automatic report_error(input string what, input logic [ADDR_W-1:0] got,
                                input logic [ADDR_W-1:0] expected);
        error_count++;
        $display("error at %0t: %s is %h, expected %h", $time, what, got, expected);
    endtask

    task automatic apply_reset();
        @(posedge ap_clk);
        #1;
        setup_areset  = 1'b1;
        descriptor_in = '0;
        repeat (4) @(posedge ap_clk);
        #1;
        setup_areset = 1'b0;
    endtask

    task automatic send_descriptor(input logic [ADDR_W-1:0] pointer);
        @(posedge ap_clk);
        #1;
        descriptor_in.valid                    = 1'b1;
        descriptor_in.payload.graph_csr_struct = pointer;
        @(posedge ap_clk);
        #1;
        descriptor_in.valid = 1'b0;
    endtask

    // Line 0 words 0 and 1, line 1 words 0 and 1
    function automatic graph_csr_config_t expected_config(input logic [ADDR_W-1:0] pointer);
        graph_csr_config_t cfg;
        logic [63:0]       line1;
        line1              = pointer + 64'(CACHELINE_BYTES);
        cfg.vertex_count   = pointer[31:0];
        cfg.edge_count     = pointer[63:32];
        cfg.out_degree_ptr = pointer + 64'd1;
        cfg.edges_src_ptr  = line1;
        cfg.edges_dest_ptr = line1 + 64'd1;
        return cfg;
    endfunction

    task automatic verify_record(input graph_csr_config_t exp_cfg);
        if (setup_config.vertex_count !== exp_cfg.vertex_count) begin
            report_error("vertex_count", setup_config.vertex_count, exp_cfg.vertex_count);
        end
        if (setup_config.edge_count !== exp_cfg.edge_count) begin
            report_error("edge_count", setup_config.edge_count, exp_cfg.edge_count);
        end
        if (setup_config.out_degree_ptr !== exp_cfg.out_degree_ptr) begin
            report_error("out_degree_ptr", setup_config.out_degree_ptr, exp_cfg.out_degree_ptr);
        end
        if (setup_config.edges_src_ptr !== exp_cfg.edges_src_ptr) begin
            report_error("edges_src_ptr", setup_config.edges_src_ptr, exp_cfg.edges_src_ptr);
        end
        if (setup_config.edges_dest_ptr !== exp_cfg.edges_dest_ptr) begin
            report_error("edges_dest_ptr", setup_config.edges_dest_ptr, exp_cfg.edges_dest_ptr);
        end
    endtask

    task automatic inspect_requests(input logic [ADDR_W-1:0] pointer);
        if (seen_addr.size() != SETUP_CACHELINES) begin
            report_error("request count", seen_addr.size(), SETUP_CACHELINES);
        end else begin
            for (int i = 0; i < SETUP_CACHELINES; i++) begin
                if (seen_addr[i] !== pointer + ADDR_W'(i * CACHELINE_BYTES)) begin
                    report_error($sformatf("request %0d address", i), seen_addr[i],
                                 pointer + ADDR_W'(i * CACHELINE_BYTES));
                end
                if (seen_id[i] !== REQ_ID_W'(i)) begin
                    report_error($sformatf("request %0d id", i), seen_id[i], i);
                end
            end
        end
    endtask

    initial begin
        // Pointer, back-pressure, reversed order
        scenarios[0] = {64'h0000_0000_0000_1000, 1'b0, 1'b0};
        scenarios[1] = {64'h0000_0000_8000_0040, 1'b1, 1'b0};
        scenarios[2] = {64'h0000_0012_3456_7880, 1'b0, 1'b1};
        scenarios[3] = {64'hffff_ffff_ffff_ff80, 1'b1, 1'b1};
        scenarios[4] = {64'h0000_7fff_dead_be00, 1'b1, 1'b1};
        scenarios[5] = {64'h0000_0000_ffff_ffc0, 1'b0, 1'b1};
        setup_areset  = 1'b1;
        descriptor_in = '0;
        backpressure  = 1'b0;
        reverse_order = 1'b0;
        error_count   = 0;
        cycle_count   = 0;

        for (int row = 0; row < NUM_ROWS; row++) begin
            backpressure  = scenarios[row].backpressure;
            reverse_order = scenarios[row].reverse_order;
            apply_reset();
            seen_addr.delete();
            seen_id.delete();

            // Quiet outputs before any descriptor
            repeat (3) begin
                @(negedge ap_clk);
                if (req_out.valid !== 1'b0 || setup_done !== 1'b0) begin
                    report_error("idle valid and done", {req_out.valid, setup_done}, 0);
                end
            end

            send_descriptor(scenarios[row].pointer);
            while (setup_done !== 1'b1) begin
                @(negedge ap_clk);
            end
            expected_cfg = expected_config(scenarios[row].pointer);
            inspect_requests(scenarios[row].pointer);
            verify_record(expected_cfg);

            // Done is sticky, a new descriptor starts nothing
            send_descriptor(scenarios[row].pointer + 64'h1000);
            repeat (QUIET_CYCLES) begin
                @(negedge ap_clk);
                if (setup_done !== 1'b1) begin
                    report_error("setup_done after second descriptor", setup_done, 1);
                end
            end
            if (seen_addr.size() != SETUP_CACHELINES) begin
                report_error("requests after second descriptor", seen_addr.size(),
                             SETUP_CACHELINES);
            end
            verify_record(expected_cfg);
        end

        $display("Rows run: %0d, errors: %0d", NUM_ROWS, error_count);
        if (error_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb/tb_memory_model.sv
`timescale 1ns/10ps
`default_nettype none

module tb_memory_model (
    input  logic                        ap_clk,
    input  logic                        areset,
    input  logic                        backpressure,
    input  logic                        reverse_order,
    input  setup_pkg::memory_request_t  req_out,
    output logic                        req_rd_en,
    output setup_pkg::memory_response_t resp_in
);

    import setup_pkg::*;

    memory_request_payload_t pending [$];
    memory_request_payload_t taken_req;
    memory_request_payload_t next_req;
    logic                    taken;
    logic                    reset_seen;
    logic                    stall_mode;
    logic                    reverse_mode;
    logic                    released;
    logic                    stall;
    int                      received;
    integer                  seed;

    initial begin
        seed       = 32'he7b268dd;
        req_rd_en  = 1'b0;
        resp_in    = '0;
        taken      = 1'b0;
        reset_seen = 1'b1;
        released   = 1'b0;
        received   = 0;
    end

    // Word k of the line at address A holds A plus k
    function automatic memory_response_t build_response(input memory_request_payload_t req);
        memory_response_t resp;
        resp.valid      = 1'b1;
        resp.payload.id = req.id;
        for (int k = 0; k < DATA_W / 64; k++) begin
            resp.payload.data[k*64 +: 64] = req.address + 64'(k);
        end
        return resp;
    endfunction

    // ----------------------------------------------------------
    // Sample handshake and mode inputs between edges
    // ----------------------------------------------------------
    always @(negedge ap_clk) begin
        taken        = req_out.valid & req_rd_en;
        taken_req    = req_out.payload;
        reset_seen   = areset;
        stall_mode   = backpressure;
        reverse_mode = reverse_order;
    end

    // ----------------------------------------------------------
    // Drive pops and responses just after the edge
    // ----------------------------------------------------------
    always @(posedge ap_clk) begin
        #1;
        if (reset_seen) begin
            pending.delete();
            released  = 1'b0;
            received  = 0;
            req_rd_en = 1'b0;
            resp_in   = '0;
        end else begin
            if (taken) begin
                pending.push_back(taken_req);
                received++;
            end
            // Reversed order waits for the whole record
            if (received >= SETUP_CACHELINES) begin
                released = 1'b1;
            end
            resp_in = '0;
            if (pending.size() > 0 && (!reverse_mode || released)) begin
                if (reverse_mode) begin
                    next_req = pending.pop_back();
                end else begin
                    next_req = pending.pop_front();
                end
                resp_in = build_response(next_req);
            end
            stall     = stall_mode && (($random(seed) & 1) != 0);
            req_rd_en = req_out.valid & ~stall;
        end
    end

endmodule

`default_nettype wire

// File: rtl/kernel_setup.sv
`timescale 1ns/10ps
`default_nettype none

module kernel_setup #(
    parameter int FIFO_DEPTH = 16
) (
    input  logic                         ap_clk,
    input  logic                         setup_areset,
    input  setup_pkg::descriptor_t       descriptor_in,
    input  setup_pkg::memory_response_t  resp_in,
    input  logic                         req_rd_en,
    output setup_pkg::memory_request_t   req_out,
    output logic                         setup_done,
    output setup_pkg::graph_csr_config_t setup_config
);

    import setup_pkg::*;

    logic areset;

    descriptor_t      desc_q;
    memory_response_t resp_q;

    kernel_setup_state_t state;
    kernel_setup_state_t next_state;

    serial_read_config_t read_config_q;
    logic                start_q;
    memory_request_t     engine_req;
    logic                engine_done;

    memory_request_t  req_fifo_dout;
    fifo_status_t     req_fifo_status;
    logic             req_fifo_rd_en;

    memory_response_t  resp_fifo_dout;
    memory_response_t  resp_fifo_out;
    fifo_status_t      resp_fifo_status;
    logic              resp_fifo_rd_en;
    graph_csr_config_t collect_config;
    logic              collect_done;

    // ----------------------------------------------------------
    // Reset and input staging
    // ----------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        areset <= setup_areset;
    end

    always_ff @(posedge ap_clk) begin
        if (areset) begin
            desc_q.valid <= 1'b0;
            resp_q.valid <= 1'b0;
        end else begin
            desc_q.valid <= descriptor_in.valid;
            resp_q.valid <= resp_in.valid;
        end
    end

    always_ff @(posedge ap_clk) begin
        desc_q.payload <= descriptor_in.payload;
        resp_q.payload <= resp_in.payload;
    end

    // ----------------------------------------------------------
    // Setup FSM
    // ----------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset) begin
            state <= SETUP_RESET;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            SETUP_RESET:     next_state = SETUP_IDLE;
            SETUP_IDLE: begin
                if (desc_q.valid) begin
                    next_state = SETUP_REQ_START;
                end
            end
            SETUP_REQ_START: next_state = SETUP_REQ_BUSY;
            SETUP_REQ_BUSY: begin
                if (engine_done && collect_done) begin
                    next_state = SETUP_DONE;
                end
            end
            // Done holds until reset, later descriptors are ignored
            SETUP_DONE:      next_state = SETUP_DONE;
            default:         next_state = SETUP_RESET;
        endcase
    end

    // Engine start level and configuration
    always_ff @(posedge ap_clk) begin
        if (areset) begin
            start_q             <= 1'b0;
            read_config_q.valid <= 1'b0;
        end else begin
            start_q             <= (state == SETUP_REQ_START) || (state == SETUP_REQ_BUSY);
            read_config_q.valid <= (state == SETUP_REQ_START) || (state == SETUP_REQ_BUSY);
        end
    end

    always_ff @(posedge ap_clk) begin
        if (state == SETUP_IDLE && desc_q.valid) begin
            read_config_q.payload.array_pointer <= desc_q.payload.graph_csr_struct;
            read_config_q.payload.start_read    <= '0;
            read_config_q.payload.end_read      <= COUNT_W'(SETUP_CACHELINES);
            read_config_q.payload.stride        <= COUNT_W'(1);
            read_config_q.payload.granularity   <= COUNT_W'(CACHELINE_BYTES);
        end
    end

    // ----------------------------------------------------------
    // Request path
    // ----------------------------------------------------------
    serial_read_engine serial_read_engine_inst (
        .ap_clk      (ap_clk),
        .areset      (areset),
        .read_config (read_config_q),
        .start       (start_q),
        .fifo_status (req_fifo_status),
        .req_out     (engine_req),
        .engine_done (engine_done)
    );

    setup_fifo #(
        .payload_t  (memory_request_t),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) req_fifo_inst (
        .ap_clk (ap_clk),
        .areset (areset),
        .din    (engine_req),
        .wr_en  (engine_req.valid),
        .rd_en  (req_fifo_rd_en),
        .dout   (req_fifo_dout),
        .status (req_fifo_status)
    );

    // Pop only into an empty output stage with no read in flight
    assign req_fifo_rd_en = ~req_fifo_status.empty & ~req_out.valid & ~req_fifo_status.valid;

    always_ff @(posedge ap_clk) begin
        if (areset) begin
            req_out.valid <= 1'b0;
        end else if (req_fifo_status.valid) begin
            req_out.valid <= 1'b1;
        end else if (req_rd_en) begin
            req_out.valid <= 1'b0;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (req_fifo_status.valid) begin
            req_out.payload <= req_fifo_dout.payload;
        end
    end

    // ----------------------------------------------------------
    // Response path
    // ----------------------------------------------------------
    setup_fifo #(
        .payload_t  (memory_response_t),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) resp_fifo_inst (
        .ap_clk (ap_clk),
        .areset (areset),
        .din    (resp_q),
        .wr_en  (resp_q.valid),
        .rd_en  (resp_fifo_rd_en),
        .dout   (resp_fifo_dout),
        .status (resp_fifo_status)
    );

    // FIFO flag marks the popped line
    assign resp_fifo_out = '{valid: resp_fifo_status.valid, payload: resp_fifo_dout.payload};

    setup_response_collector setup_response_collector_inst (
        .ap_clk       (ap_clk),
        .areset       (areset),
        .resp_dout    (resp_fifo_out),
        .fifo_status  (resp_fifo_status),
        .rd_en        (resp_fifo_rd_en),
        .setup_config (collect_config),
        .collect_done (collect_done)
    );

    // ----------------------------------------------------------
    // Output staging
    // ----------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset) begin
            setup_done <= 1'b0;
        end else begin
            setup_done <= (state == SETUP_DONE);
        end
    end

    always_ff @(posedge ap_clk) begin
        setup_config <= collect_config;
    end

endmodule

`default_nettype wire

// File: rtl/setup_response_collector.sv
`timescale 1ns/10ps
`default_nettype none

module setup_response_collector (
    input  logic                           ap_clk,
    input  logic                           areset,
    input  setup_pkg::memory_response_t    resp_dout,
    input  setup_pkg::fifo_status_t        fifo_status,
    output logic                           rd_en,
    output setup_pkg::graph_csr_config_t   setup_config,
    output logic                           collect_done
);

    import setup_pkg::*;

    localparam int SLOT_W = (SETUP_CACHELINES > 1) ? $clog2(SETUP_CACHELINES) : 1;

    logic [DATA_W-1:0]           line_q [SETUP_CACHELINES];
    logic [SETUP_CACHELINES-1:0] filled_q;
    logic [SLOT_W-1:0]           slot;
    logic                        slot_ok;

    // Drain whatever has arrived
    assign rd_en = ~fifo_status.empty;

    // Response id picks the slot, so arrival order does not matter
    assign slot    = resp_dout.payload.id[SLOT_W-1:0];
    assign slot_ok = resp_dout.valid &
                     (resp_dout.payload.id < REQ_ID_W'(SETUP_CACHELINES));

    // ----------------------------------------------------------
    // Line slots
    // ----------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (slot_ok) begin
            line_q[slot] <= resp_dout.payload.data;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (areset) begin
            filled_q     <= '0;
            collect_done <= 1'b0;
        end else begin
            if (slot_ok) begin
                filled_q[slot] <= 1'b1;
            end
            // Sticky until reset
            if (&filled_q) begin
                collect_done <= 1'b1;
            end
        end
    end

    // ----------------------------------------------------------
    // Record assembly
    // ----------------------------------------------------------
    always_comb begin
        setup_config.vertex_count   = line_q[0][31:0];
        setup_config.edge_count     = line_q[0][63:32];
        setup_config.out_degree_ptr = line_q[0][127:64];
        // Second line holds the edge arrays
        setup_config.edges_src_ptr  = line_q[1][63:0];
        setup_config.edges_dest_ptr = line_q[1][127:64];
    end

endmodule

`default_nettype wire

// File: rtl/serial_read_engine.sv
`timescale 1ns/10ps
`default_nettype none

module serial_read_engine (
    input  logic                           ap_clk,
    input  logic                           areset,
    input  setup_pkg::serial_read_config_t read_config,
    input  logic                           start,
    input  setup_pkg::fifo_status_t        fifo_status,
    output setup_pkg::memory_request_t     req_out,
    output logic                           engine_done
);

    import setup_pkg::*;

    logic               active_q;
    logic               launch;
    logic               push;
    logic               last_push;
    logic [COUNT_W-1:0] index_q;
    logic [COUNT_W-1:0] end_q;
    logic [ADDR_W-1:0]  addr_q;
    logic [ADDR_W-1:0]  step_q;
    logic [ADDR_W-1:0]  step;
    logic               has_work;

    // Byte distance between two consecutive requests
    assign step = ADDR_W'(read_config.payload.stride) *
                  ADDR_W'(read_config.payload.granularity);

    assign has_work = (read_config.payload.start_read < read_config.payload.end_read);

    // Latch the configuration once per reset
    assign launch = start & read_config.valid & ~active_q & ~engine_done;

    // Back-pressure: hold the current index while the FIFO is full
    assign push      = active_q & ~fifo_status.full;
    assign last_push = push & ((index_q + 1'b1) == end_q);

    // ----------------------------------------------------------
    // Control
    // ----------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset) begin
            active_q    <= 1'b0;
            engine_done <= 1'b0;
        end else if (launch) begin
            active_q <= has_work;
            // Empty range finishes at once
            engine_done <= ~has_work;
        end else if (last_push) begin
            active_q    <= 1'b0;
            engine_done <= 1'b1;
        end
    end

    // ----------------------------------------------------------
    // Index and address walk
    // ----------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (launch) begin
            index_q <= read_config.payload.start_read;
            end_q   <= read_config.payload.end_read;
            step_q  <= step;
            addr_q  <= read_config.payload.array_pointer +
                       ADDR_W'(read_config.payload.start_read) * step;
        end else if (push) begin
            index_q <= index_q + 1'b1;
            addr_q  <= addr_q + step_q;
        end
    end

    // Request is the FIFO write, valid doubles as wr_en
    always_comb begin
        req_out.valid           = push;
        req_out.payload.address = addr_q;
        req_out.payload.id      = index_q[REQ_ID_W-1:0];
    end

endmodule

`default_nettype wire

// File: rtl/setup_fifo.sv
`timescale 1ns/10ps
`default_nettype none

module setup_fifo #(
    parameter type payload_t  = logic [7:0],
    parameter int  FIFO_DEPTH = 16
) (
    input  logic                    ap_clk,
    input  logic                    areset,
    input  payload_t                din,
    input  logic                    wr_en,
    input  logic                    rd_en,
    output payload_t                dout,
    output setup_pkg::fifo_status_t status
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);

    payload_t mem [FIFO_DEPTH];

    // One extra pointer bit tells full from empty
    logic [PTR_W:0] wr_ptr;
    logic [PTR_W:0] rd_ptr;
    logic [PTR_W:0] count;

    logic full;
    logic almost_full;
    logic empty;
    logic push;
    logic pop;
    logic valid_q;

    assign count       = wr_ptr - rd_ptr;
    assign full        = (count == (PTR_W + 1)'(FIFO_DEPTH));
    assign almost_full = (count >= (PTR_W + 1)'(FIFO_DEPTH - 1));
    assign empty       = (count == '0);

    // Requests against a full or empty buffer are ignored
    assign push = wr_en & ~full;
    assign pop  = rd_en & ~empty;

    // ----------------------------------------------------------
    // Pointers and read valid
    // ----------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            valid_q <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            valid_q <= pop;
        end
    end

    // ----------------------------------------------------------
    // Storage, one cycle read latency
    // ----------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (push) begin
            mem[wr_ptr[PTR_W-1:0]] <= din;
        end
        if (pop) begin
            dout <= mem[rd_ptr[PTR_W-1:0]];
        end
    end

    always_comb begin
        status.full        = full;
        status.almost_full = almost_full;
        status.empty       = empty;
        status.valid       = valid_q;
    end

endmodule

`default_nettype wire

// File: rtl/setup_pkg.sv
`default_nettype none

package setup_pkg;

    // ----------------------------------------------------------
    // Widths and record geometry
    // ----------------------------------------------------------
    parameter int ADDR_W           = 64;
    parameter int CACHELINE_BYTES  = 64;
    parameter int DATA_W           = 512;
    parameter int REQ_ID_W         = 4;
    parameter int COUNT_W          = 32;
    // Record layout is tied to this line count
    parameter int SETUP_CACHELINES = 2;

    // ----------------------------------------------------------
    // Memory packets
    // ----------------------------------------------------------
    typedef struct packed {
        logic [ADDR_W-1:0]   address;
        logic [REQ_ID_W-1:0] id;
    } memory_request_payload_t;

    typedef struct packed {
        logic                    valid;
        memory_request_payload_t payload;
    } memory_request_t;

    typedef struct packed {
        logic [REQ_ID_W-1:0] id;
        logic [DATA_W-1:0]   data;
    } memory_response_payload_t;

    typedef struct packed {
        logic                     valid;
        memory_response_payload_t payload;
    } memory_response_t;

    // FIFO state flags, valid marks dout
    typedef struct packed {
        logic full;
        logic almost_full;
        logic empty;
        logic valid;
    } fifo_status_t;

    // ----------------------------------------------------------
    // Host descriptor and read configuration
    // ----------------------------------------------------------
    typedef struct packed {
        logic [ADDR_W-1:0] graph_csr_struct;
    } descriptor_payload_t;

    typedef struct packed {
        logic                valid;
        descriptor_payload_t payload;
    } descriptor_t;

    typedef struct packed {
        logic [ADDR_W-1:0]  array_pointer;
        logic [COUNT_W-1:0] start_read;
        logic [COUNT_W-1:0] end_read;
        // Stride in lines, granularity in bytes
        logic [COUNT_W-1:0] stride;
        logic [COUNT_W-1:0] granularity;
    } serial_read_config_payload_t;

    typedef struct packed {
        logic                        valid;
        serial_read_config_payload_t payload;
    } serial_read_config_t;

    // Unpacked graph structure record
    typedef struct packed {
        logic [31:0] vertex_count;
        logic [31:0] edge_count;
        logic [63:0] out_degree_ptr;
        logic [63:0] edges_src_ptr;
        logic [63:0] edges_dest_ptr;
    } graph_csr_config_t;

    typedef enum logic [2:0] {
        SETUP_RESET,
        SETUP_IDLE,
        SETUP_REQ_START,
        SETUP_REQ_BUSY,
        SETUP_DONE
    } kernel_setup_state_t;

endpackage

`default_nettype wire
